//--- Makefile
# Verilator simulation of the memory-mapped I/O block

VERILATOR ?= verilator
TOP       ?= tb_mmio_top
RTL_TOP   ?= mmio_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Output is shown and searched for the pass line; the status comes from grep
run: build
	$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- button_capture.sv
`timescale 1ns/10ps

module button_capture (
    input  logic              clk,
    input  logic              rst_n,
    input  mmio_pkg::button_t buttons,
    input  logic              full,
    output logic              wr_en,
    output mmio_pkg::button_t din
);
    import mmio_pkg::*;

    button_t sync_q [SYNC_STAGES];
    button_t prev_q;  // Last synchronized sample
    button_t rose;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
            prev_q <= '0;
        end else begin
            sync_q[0] <= buttons;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
            prev_q <= sync_q[SYNC_STAGES-1];
        end
    end

    assign rose  = sync_q[SYNC_STAGES-1] & ~prev_q;
    assign din   = rose;
    assign wr_en = (|rose) && !full;  // Event lost when queue is full

endmodule

//--- mmio_pkg.sv
package mmio_pkg;

    typedef logic [31:0] io_word_t;  // Bus data word
    typedef logic [7:0]  io_addr_t;  // Byte offset in I/O region
    typedef logic [7:0]  byte_t;     // UART byte
    typedef logic [5:0]  led_t;
    typedef logic [11:0] duty_t;
    typedef logic [2:0]  button_t;
    typedef logic [1:0]  switch_t;

    // One bus access as issued by the execute and writeback stages
    typedef struct packed {
        logic     wr_en;  // Store strobe
        logic     rd_en;  // Load strobe
        io_addr_t addr;
        io_word_t wdata;
    } io_req_t;

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} uart_state_t;

    localparam io_addr_t ADDR_UART_CTRL = 8'h00;  // Bit 0 tx not full, bit 1 rx not empty
    localparam io_addr_t ADDR_UART_RX   = 8'h04;  // Load pops receive queue
    localparam io_addr_t ADDR_UART_TX   = 8'h08;
    localparam io_addr_t ADDR_CYCLE     = 8'h10;
    localparam io_addr_t ADDR_CYCLE_RST = 8'h18;
    localparam io_addr_t ADDR_BTN_CTRL  = 8'h20;  // Bit 0 button queue empty
    localparam io_addr_t ADDR_BTN_DATA  = 8'h24;  // Load pops button queue
    localparam io_addr_t ADDR_SWITCHES  = 8'h28;
    localparam io_addr_t ADDR_LEDS      = 8'h30;
    localparam io_addr_t ADDR_DUTY      = 8'h34;  // Read gives req pending

    localparam int FIFO_DEPTH     = 32;
    localparam int FIFO_AW        = $clog2(FIFO_DEPTH);
    localparam int CPU_CLOCK_FREQ = 50_000_000;
    localparam int BAUD_RATE      = 115_200;
    localparam int CLKS_PER_BIT   = CPU_CLOCK_FREQ / BAUD_RATE;  // 434
    localparam int UART_CNT_W     = $clog2(CLKS_PER_BIT);
    localparam int SYNC_STAGES    = 2;

endpackage

//--- mmio_regs.sv
`timescale 1ns/10ps

module mmio_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  mmio_pkg::io_req_t  req,
    input  logic               tx_full,
    input  logic               rx_empty,
    input  mmio_pkg::byte_t    rx_data,
    input  logic               btn_empty,
    input  mmio_pkg::button_t  btn_data,
    input  mmio_pkg::switch_t  switches,
    input  logic               ack,
    output mmio_pkg::io_word_t rdata,
    output logic               tx_push,
    output mmio_pkg::byte_t    tx_byte,
    output logic               rx_pop,
    output logic               btn_pop,
    output mmio_pkg::led_t     leds,
    output mmio_pkg::duty_t    duty_cycle,
    output logic               duty_req
);
    import mmio_pkg::*;

    io_word_t cycle_cnt;
    io_word_t rd_mux;
    logic     cycle_clr;
    logic     led_we;
    logic     duty_we;

    // Store decode
    assign tx_push   = req.wr_en && (req.addr == ADDR_UART_TX);
    assign tx_byte   = req.wdata[7:0];
    assign cycle_clr = req.wr_en && (req.addr == ADDR_CYCLE_RST);
    assign led_we    = req.wr_en && (req.addr == ADDR_LEDS);
    assign duty_we   = req.wr_en && (req.addr == ADDR_DUTY) && !duty_req;

    // Load side effects happen in the strobe cycle
    assign rx_pop  = req.rd_en && (req.addr == ADDR_UART_RX);
    assign btn_pop = req.rd_en && (req.addr == ADDR_BTN_DATA);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_cnt <= '0;
        end else if (cycle_clr) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            leds <= '0;
        end else if (led_we) begin
            leds <= req.wdata[5:0];
        end
    end

    // Duty value stays fixed until the consumer acknowledges
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            duty_cycle <= '0;
            duty_req   <= 1'b0;
        end else if (duty_we) begin
            duty_cycle <= req.wdata[11:0];
            duty_req   <= 1'b1;
        end else if (duty_req && ack) begin
            duty_req <= 1'b0;
        end
    end

    always_comb begin
        case (req.addr)
            ADDR_UART_CTRL: rd_mux = io_word_t'({!rx_empty, !tx_full});
            ADDR_UART_RX:   rd_mux = rx_empty ? '0 : io_word_t'(rx_data);
            ADDR_CYCLE:     rd_mux = cycle_cnt;
            ADDR_BTN_CTRL:  rd_mux = io_word_t'(btn_empty);
            ADDR_BTN_DATA:  rd_mux = btn_empty ? '0 : io_word_t'(btn_data);
            ADDR_SWITCHES:  rd_mux = io_word_t'(switches);
            ADDR_LEDS:      rd_mux = io_word_t'(leds);
            ADDR_DUTY:      rd_mux = io_word_t'(duty_req);
            default:        rd_mux = '0;  // Unmapped offset
        endcase
    end

    // Load result held until next load
    always_ff @(posedge clk) begin
        if (req.rd_en) begin
            rdata <= rd_mux;
        end
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !(req.wr_en && req.rd_en));

    a_req_needs_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(duty_req) |-> $past(ack));

endmodule

//--- mmio_top.sv
`timescale 1ns/10ps

module mmio_top (
    input  logic               clk,
    input  logic               rst_n,
    input  mmio_pkg::io_req_t  req,
    input  mmio_pkg::button_t  buttons,
    input  mmio_pkg::switch_t  switches,
    input  logic               ack,
    input  logic               serial_rx,
    output mmio_pkg::io_word_t rdata,
    output mmio_pkg::led_t     leds,
    output mmio_pkg::duty_t    duty_cycle,
    output logic               req_out,
    output logic               serial_tx
);
    import mmio_pkg::*;

    logic    tx_push;
    byte_t   tx_byte;
    logic    tx_full;
    logic    tx_pop;
    byte_t   tx_dout;
    logic    tx_empty;
    logic    tx_ready;

    logic    rx_push;
    logic    rx_valid;
    byte_t   rx_byte;
    logic    rx_full;
    logic    rx_pop;
    byte_t   rx_dout;
    logic    rx_empty;

    logic    btn_push;
    button_t btn_din;
    logic    btn_full;
    logic    btn_pop;
    button_t btn_dout;
    logic    btn_empty;

    assign tx_pop  = tx_ready && !tx_empty;  // Byte taken by transmitter
    assign rx_push = rx_valid && !rx_full;

    mmio_regs regs (
        .clk(clk),
        .rst_n(rst_n),
        .req(req),
        .tx_full(tx_full),
        .rx_empty(rx_empty),
        .rx_data(rx_dout),
        .btn_empty(btn_empty),
        .btn_data(btn_dout),
        .switches(switches),
        .ack(ack),
        .rdata(rdata),
        .tx_push(tx_push),
        .tx_byte(tx_byte),
        .rx_pop(rx_pop),
        .btn_pop(btn_pop),
        .leds(leds),
        .duty_cycle(duty_cycle),
        .duty_req(req_out)
    );

    sync_fifo #(.WIDTH($bits(byte_t))) tx_fifo (
        .clk(clk), .rst_n(rst_n),
        .wr_en(tx_push), .din(tx_byte), .full(tx_full),
        .rd_en(tx_pop), .dout(tx_dout), .empty(tx_empty)
    );

    sync_fifo #(.WIDTH($bits(byte_t))) rx_fifo (
        .clk(clk), .rst_n(rst_n),
        .wr_en(rx_push), .din(rx_byte), .full(rx_full),
        .rd_en(rx_pop), .dout(rx_dout), .empty(rx_empty)
    );

    sync_fifo #(.WIDTH($bits(button_t))) btn_fifo (
        .clk(clk), .rst_n(rst_n),
        .wr_en(btn_push), .din(btn_din), .full(btn_full),
        .rd_en(btn_pop), .dout(btn_dout), .empty(btn_empty)
    );

    uart on_chip_uart (
        .clk(clk),
        .rst_n(rst_n),
        .tx_byte(tx_dout),
        .tx_valid(!tx_empty),
        .serial_rx(serial_rx),
        .tx_ready(tx_ready),
        .rx_byte(rx_byte),
        .rx_valid(rx_valid),
        .serial_tx(serial_tx)
    );

    button_capture btn_capture (
        .clk(clk),
        .rst_n(rst_n),
        .buttons(buttons),
        .full(btn_full),
        .wr_en(btn_push),
        .din(btn_din)
    );

endmodule

//--- sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo #(
    parameter int WIDTH = $bits(mmio_pkg::byte_t)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             full,
    output logic             empty
);
    import mmio_pkg::*;

    logic [WIDTH-1:0] mem [FIFO_DEPTH];
    logic [FIFO_AW:0] wr_ptr;  // Extra MSB is the wrap flag
    logic [FIFO_AW:0] rd_ptr;
    logic             do_wr;
    logic             do_rd;

    assign do_wr = wr_en && !full;  // Push while full is dropped
    assign do_rd = rd_en && !empty;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                   (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);

    // First word falls through to the output
    assign dout = mem[rd_ptr[FIFO_AW-1:0]];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr[FIFO_AW-1:0]] <= din;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Head entry stays put until popped
    a_head_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (!empty && !rd_en) |=> $stable(dout));

endmodule

//--- tb_mmio_top.sv
`timescale 1ns/10ps

module tb_mmio_top;
    import mmio_pkg::*;

    localparam int          POLL_LIMIT = 20000;  // Bus reads per poll
    localparam int          CYCLE_GAP  = 9;
    localparam int          CLEAR_WAIT = 5;
    localparam int          NUM_BYTES  = 4;
    localparam logic [31:0] SEED       = 32'ha435_8637;

    logic      clk;
    logic      rst_n;
    io_req_t   req;
    button_t   buttons;
    switch_t   switches;
    logic      ack;
    logic      serial_rx;
    io_word_t  rdata;
    led_t      leds;
    duty_t     duty_cycle;
    logic      req_out;
    logic      serial_tx;

    led_t      exp_leds;  // Model of the LED register
    byte_t     sent_q[$];

    assign serial_rx = serial_tx;  // UART loopback

    mmio_top UUT (
        .clk(clk),
        .rst_n(rst_n),
        .req(req),
        .buttons(buttons),
        .switches(switches),
        .ack(ack),
        .serial_rx(serial_rx),
        .rdata(rdata),
        .leds(leds),
        .duty_cycle(duty_cycle),
        .req_out(req_out),
        .serial_tx(serial_tx)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic check_value(input string name, input io_word_t expected,
                               input io_word_t actual);
        assert (actual === expected) else begin
            $display("error: %s expected 0x%h got 0x%h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    // Called and returning 2 ns after a rising edge
    task automatic bus_write(input io_addr_t addr, input io_word_t data);
        req.wr_en = 1'b1;
        req.rd_en = 1'b0;
        req.addr  = addr;
        req.wdata = data;
        @(posedge clk);
        #2;
        req = '0;
        if (addr == ADDR_LEDS) begin
            exp_leds = data[5:0];
        end
    endtask

    task automatic bus_read(input io_addr_t addr, output io_word_t data);
        req.wr_en = 1'b0;
        req.rd_en = 1'b1;
        req.addr  = addr;
        req.wdata = '0;
        @(posedge clk);
        #2;
        req  = '0;
        data = rdata;  // Registered on the strobe edge
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic poll_bit(input io_addr_t addr, input int bit_idx, input logic value,
                            input string what);
        io_word_t data;
        int       polls;
        polls = 0;
        bus_read(addr, data);
        while (data[bit_idx] !== value && polls < POLL_LIMIT) begin
            bus_read(addr, data);
            polls++;
        end
        if (data[bit_idx] !== value) begin
            $display("timeout: %s did not happen within %0d bus reads", what, POLL_LIMIT);
            stop_with_failure();
        end
    endtask

    a_leds_match: assert property (@(posedge clk) disable iff (!rst_n)
        leds == exp_leds)
    else begin
        $display("error: leds expected 0x%h got 0x%h", exp_leds, leds);
        stop_with_failure();
    end

    a_duty_held: assert property (@(posedge clk) disable iff (!rst_n)
        req_out |=> $stable(duty_cycle))
    else begin
        $display("duty_cycle changed while the request was pending");
        stop_with_failure();
    end

    a_req_drops: assert property (@(posedge clk) disable iff (!rst_n)
        (req_out && ack) |=> !req_out)
    else begin
        $display("req_out stayed high after ack was seen");
        stop_with_failure();
    end

    initial begin
        io_word_t data;
        io_word_t first;
        led_t     led_val;
        duty_t    duty_val;
        byte_t    tx_val;
        int       polls;
        void'($urandom(SEED));
        rst_n    = 1'b0;
        req      = '0;
        buttons  = '0;
        switches = '0;
        ack      = 1'b0;
        exp_leds = '0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;

        check_value("leds", 32'h0, io_word_t'(leds));
        check_value("duty_cycle", 32'h0, io_word_t'(duty_cycle));
        check_value("req_out", 32'h0, io_word_t'(req_out));
        check_value("serial_tx", 32'h1, io_word_t'(serial_tx));
        bus_read(ADDR_UART_CTRL, data);
        check_value("uart_ctrl", 32'h1, data);
        bus_read(ADDR_BTN_CTRL, data);
        check_value("btn_ctrl", 32'h1, data);

        led_val = led_t'($urandom);
        bus_write(ADDR_LEDS, io_word_t'(led_val));
        check_value("leds", io_word_t'(led_val), io_word_t'(leds));
        bus_read(ADDR_LEDS, data);
        check_value("led readback", io_word_t'(led_val), data);

        for (int i = 0; i < NUM_BYTES; i++) begin
            poll_bit(ADDR_UART_CTRL, 0, 1'b1, "transmit queue space");
            tx_val = byte_t'($urandom);
            sent_q.push_back(tx_val);
            bus_write(ADDR_UART_TX, io_word_t'(tx_val));
        end
        for (int i = 0; i < NUM_BYTES; i++) begin
            poll_bit(ADDR_UART_CTRL, 1, 1'b1, "arrival of a looped-back byte");
            bus_read(ADDR_UART_RX, data);
            check_value("uart rx byte", io_word_t'(sent_q.pop_front()), data);
        end
        bus_read(ADDR_UART_CTRL, data);
        check_value("uart_ctrl rx not empty", 32'h0, io_word_t'(data[1]));

        buttons = 3'b010;
        poll_bit(ADDR_BTN_CTRL, 0, 1'b0, "button event in the queue");
        bus_read(ADDR_BTN_DATA, data);
        check_value("btn_data", 32'h2, data);
        bus_read(ADDR_BTN_CTRL, data);
        check_value("btn_ctrl", 32'h1, data);
        idle_cycles(20);  // Held button must not queue again
        bus_read(ADDR_BTN_CTRL, data);
        check_value("btn_ctrl", 32'h1, data);
        buttons  = '0;
        switches = 2'b10;
        bus_read(ADDR_SWITCHES, data);
        check_value("switches", 32'h2, data);

        bus_read(ADDR_CYCLE, first);
        idle_cycles(CYCLE_GAP - 1);
        bus_read(ADDR_CYCLE, data);
        check_value("cycle delta", io_word_t'(CYCLE_GAP), data - first);
        bus_write(ADDR_CYCLE_RST, '0);
        idle_cycles(CLEAR_WAIT);
        bus_read(ADDR_CYCLE, data);
        check_value("cycle after clear", io_word_t'(CLEAR_WAIT), data);

        duty_val = duty_t'($urandom);
        bus_write(ADDR_DUTY, io_word_t'(duty_val));
        check_value("duty_cycle", io_word_t'(duty_val), io_word_t'(duty_cycle));
        check_value("req_out", 32'h1, io_word_t'(req_out));
        bus_read(ADDR_DUTY, data);
        check_value("duty pending", 32'h1, data);
        bus_write(ADDR_DUTY, io_word_t'(~duty_val));  // Ignored while pending
        check_value("duty_cycle", io_word_t'(duty_val), io_word_t'(duty_cycle));
        ack   = 1'b1;
        polls = 0;
        while (req_out && polls < POLL_LIMIT) begin
            idle_cycles(1);
            polls++;
        end
        if (req_out) begin
            $display("timeout: req_out did not fall after ack was raised");
            stop_with_failure();
        end
        ack = 1'b0;
        bus_read(ADDR_DUTY, data);
        check_value("duty pending", 32'h0, data);

        idle_cycles(2);
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- uart.sv
`timescale 1ns/10ps

module uart (
    input  logic            clk,
    input  logic            rst_n,
    input  mmio_pkg::byte_t tx_byte,
    input  logic            tx_valid,
    input  logic            serial_rx,
    output logic            tx_ready,
    output mmio_pkg::byte_t rx_byte,
    output logic            rx_valid,
    output logic            serial_tx
);
    import mmio_pkg::*;

    uart_state_t           tx_state;
    logic [UART_CNT_W-1:0] tx_cnt;
    logic [2:0]            tx_bit;
    byte_t                 tx_shift;
    logic                  tx_bit_end;

    uart_state_t           rx_state;
    logic [UART_CNT_W-1:0] rx_cnt;
    logic [2:0]            rx_bit;
    byte_t                 rx_shift;
    logic [SYNC_STAGES-1:0] rx_sync;
    logic                  rx_in;
    logic                  rx_mid;
    logic                  rx_bit_end;

    assign tx_bit_end = (tx_cnt == UART_CNT_W'(CLKS_PER_BIT - 1));
    assign tx_ready   = (tx_state == IDLE);

    always_comb begin
        case (tx_state)
            START:   serial_tx = 1'b0;
            DATA:    serial_tx = tx_shift[0];  // LSB first
            default: serial_tx = 1'b1;         // Idle line and stop bit
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_state <= IDLE;
            tx_cnt   <= '0;
            tx_bit   <= '0;
        end else begin
            if (tx_state == IDLE || tx_bit_end) begin
                tx_cnt <= '0;
            end else begin
                tx_cnt <= tx_cnt + 1'b1;
            end
            case (tx_state)
                IDLE: begin
                    if (tx_valid) begin
                        tx_state <= START;
                    end
                end
                START: begin
                    if (tx_bit_end) begin
                        tx_state <= DATA;
                        tx_bit   <= '0;
                    end
                end
                DATA: begin
                    if (tx_bit_end) begin
                        tx_bit <= tx_bit + 1'b1;
                        if (tx_bit == 3'd7) begin
                            tx_state <= STOP;
                        end
                    end
                end
                default: begin
                    if (tx_bit_end) begin
                        tx_state <= IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (tx_valid && tx_ready) begin
            tx_shift <= tx_byte;
        end else if (tx_state == DATA && tx_bit_end) begin
            tx_shift <= {1'b0, tx_shift[7:1]};
        end
    end

    // Receive line comes from another clock domain
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_sync <= '1;
        end else begin
            rx_sync <= {rx_sync[SYNC_STAGES-2:0], serial_rx};
        end
    end

    assign rx_in      = rx_sync[SYNC_STAGES-1];
    assign rx_mid     = (rx_cnt == UART_CNT_W'(CLKS_PER_BIT / 2 - 1));
    assign rx_bit_end = (rx_cnt == UART_CNT_W'(CLKS_PER_BIT - 1));
    assign rx_byte    = rx_shift;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_state <= IDLE;
            rx_cnt   <= '0;
            rx_bit   <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            rx_cnt   <= rx_cnt + 1'b1;
            case (rx_state)
                IDLE: begin
                    rx_cnt <= '0;
                    if (!rx_in) begin
                        rx_state <= START;
                    end
                end
                START: begin
                    if (rx_mid) begin  // Later sampling lands mid-bit
                        rx_cnt   <= '0;
                        rx_bit   <= '0;
                        rx_state <= rx_in ? IDLE : DATA;  // Glitch goes back to idle
                    end
                end
                DATA: begin
                    if (rx_bit_end) begin
                        rx_cnt <= '0;
                        rx_bit <= rx_bit + 1'b1;
                        if (rx_bit == 3'd7) begin
                            rx_state <= STOP;
                        end
                    end
                end
                default: begin
                    if (rx_bit_end) begin
                        rx_cnt   <= '0;
                        rx_state <= IDLE;
                        rx_valid <= rx_in;  // Framing error drops the byte
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rx_state == DATA && rx_bit_end) begin
            rx_shift <= {rx_in, rx_shift[7:1]};
        end
    end

    a_rx_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        rx_valid |=> !rx_valid);

endmodule

//--- vlog.f
mmio_pkg.sv
sync_fifo.sv
uart.sv
button_capture.sv
mmio_regs.sv
mmio_top.sv
tb_mmio_top.sv
